/* design/dvb_mod_pkg.sv */
`default_nettype none

package dvb_mod_pkg;

	localparam int REG_DATA_BITS = 32;
	localparam int REG_ADDR_BITS = 4;
	localparam int REG_STRB_BITS = REG_DATA_BITS / 8;

	typedef logic [REG_DATA_BITS-1:0] reg_data_t;
	typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;
	typedef logic [REG_STRB_BITS-1:0] reg_strb_t;

	typedef logic [7:0] ts_byte_t;
	typedef logic signed [15:0] sample_t;

	typedef struct packed {
		sample_t im; // upper half
		sample_t re; // lower half
	} iq_t;

	typedef enum logic {
		MOD_QPSK = 1'b0,
		MOD_APSK16 = 1'b1
	} mod_mode_t;

	// register map
	localparam reg_addr_t ADDR_MOD_MODE = 4'd0;
	localparam reg_addr_t ADDR_FREQ_INV = 4'd1;
	localparam reg_addr_t ADDR_BYTE_COUNT = 4'd2; // read only
	localparam reg_addr_t ADDR_SAMPLE_COUNT = 4'd3; // read only

	localparam mod_mode_t MOD_MODE_RESET = MOD_QPSK;
	localparam logic FREQ_INV_RESET = 1'b0;

	localparam logic [15:0] UNMAPPED_TAG = 16'hE000; // lower half carries raddr

	localparam sample_t QPSK_AMP = 16'sd11585; // ~ 16384 / sqrt(2)

	// 16APSK points on an outer ring of radius 14000 and an inner ring of radius 4900
	// symbols 0..11 sit on the outer ring, 12..15 on the inner ring
	localparam sample_t APSK16_RE [16] = '{
		16'sd9899, 16'sd9899, -16'sd9899, -16'sd9899,
		16'sd13523, 16'sd13523, -16'sd13523, -16'sd13523,
		16'sd3623, 16'sd3623, -16'sd3623, -16'sd3623,
		16'sd3465, 16'sd3465, -16'sd3465, -16'sd3465
	};

	localparam sample_t APSK16_IM [16] = '{
		16'sd9899, -16'sd9899, 16'sd9899, -16'sd9899,
		16'sd3623, -16'sd3623, 16'sd3623, -16'sd3623,
		16'sd13523, -16'sd13523, 16'sd13523, -16'sd13523,
		16'sd3465, -16'sd3465, 16'sd3465, -16'sd3465
	};

endpackage

`default_nettype wire

/* design/stream_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module stream_stage #(
	parameter type payload_t = logic [7:0]
) (
	input wire clk,
	input wire hard_rst_n,

	input payload_t in_data,
	input wire in_valid,
	output logic in_ready,

	output payload_t out_data,
	output logic out_valid,
	input wire out_ready
);

	// accept when empty or when the held item leaves this cycle
	assign in_ready = !out_valid || out_ready;

	always_ff @(posedge clk) begin
		if (!hard_rst_n) begin
			out_valid <= 1'b0;
		end
		else begin
			if (in_valid && in_ready) begin
				out_valid <= 1'b1;
			end
			else if (out_ready) begin
				out_valid <= 1'b0; // drained
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			out_data <= in_data;
		end
	end

endmodule

`default_nettype wire

/* design/dvb_cfg_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module dvb_cfg_regs (
	input wire clk,
	input wire hard_rst_n,

	input wire wen,
	input dvb_mod_pkg::reg_addr_t waddr,
	input dvb_mod_pkg::reg_data_t wdata,
	input dvb_mod_pkg::reg_strb_t wstrb,

	input wire ren,
	input dvb_mod_pkg::reg_addr_t raddr,
	output dvb_mod_pkg::reg_data_t rdata,

	input wire byte_fire,
	input wire sample_fire,

	output dvb_mod_pkg::mod_mode_t mod_mode,
	output logic freq_inv
);

	import dvb_mod_pkg::*;

	logic wr_pend; // staged write waiting to land
	reg_addr_t wr_addr;
	reg_data_t wr_data;
	reg_strb_t wr_strb;

	reg_data_t byte_count;
	reg_data_t sample_count;

	// write staging for one cycle
	always_ff @(posedge clk) begin
		if (!hard_rst_n) begin
			wr_pend <= 1'b0;
		end
		else begin
			wr_pend <= wen;
		end
	end

	always_ff @(posedge clk) begin
		if (wen) begin
			wr_addr <= waddr;
			wr_data <= wdata;
			wr_strb <= wstrb;
		end
	end

	// both config fields live in byte 0, so only that strobe matters
	always_ff @(posedge clk) begin
		if (!hard_rst_n) begin
			mod_mode <= MOD_MODE_RESET;
			freq_inv <= FREQ_INV_RESET;
		end
		else begin
			if (wr_pend && wr_strb[0]) begin
				case (wr_addr)
					ADDR_MOD_MODE: begin
						mod_mode <= mod_mode_t'(wr_data[0]);
					end
					ADDR_FREQ_INV: begin
						freq_inv <= wr_data[0];
					end
					default: begin
						// counters and unmapped space ignore writes
					end
				endcase
			end
		end
	end

	// activity counters wrap at 2^32
	always_ff @(posedge clk) begin
		if (!hard_rst_n) begin
			byte_count <= '0;
			sample_count <= '0;
		end
		else begin
			if (byte_fire) begin
				byte_count <= byte_count + 1'b1;
			end
			if (sample_fire) begin
				sample_count <= sample_count + 1'b1;
			end
		end
	end

	// registered read held until the next ren
	always_ff @(posedge clk) begin
		if (!hard_rst_n) begin
			rdata <= '0;
		end
		else begin
			if (ren) begin
				case (raddr)
					ADDR_MOD_MODE: rdata <= reg_data_t'(mod_mode);
					ADDR_FREQ_INV: rdata <= reg_data_t'(freq_inv);
					ADDR_BYTE_COUNT: rdata <= byte_count;
					ADDR_SAMPLE_COUNT: rdata <= sample_count;
					default: begin
						rdata <= {UNMAPPED_TAG, {(16 - REG_ADDR_BITS){1'b0}}, raddr};
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* design/constellation_mapper.sv */
`timescale 1ns/100ps
`default_nettype none

module constellation_mapper (
	input wire clk,
	input wire hard_rst_n,

	input dvb_mod_pkg::mod_mode_t mod_mode,
	input wire freq_inv,

	input dvb_mod_pkg::ts_byte_t byte_data,
	input wire byte_valid,
	output logic byte_ready,

	output dvb_mod_pkg::iq_t sym_data,
	output logic sym_valid,
	input wire sym_ready
);

	import dvb_mod_pkg::*;

	logic busy;
	logic [1:0] sym_cnt; // symbols left after the current one
	ts_byte_t shreg; // msb end holds the current symbol bits
	mod_mode_t mode_q;
	logic inv_q;
	sample_t re_pt;
	sample_t im_pt;

	assign byte_ready = !busy;
	assign sym_valid = busy;

	always_ff @(posedge clk) begin
		if (!hard_rst_n) begin
			busy <= 1'b0;
			sym_cnt <= '0;
		end
		else begin
			if (byte_valid && byte_ready) begin
				busy <= 1'b1;
				sym_cnt <= (mod_mode == MOD_QPSK) ? 2'd3 : 2'd1;
			end
			else if (sym_valid && sym_ready) begin
				if (sym_cnt == 2'd0) begin
					busy <= 1'b0; // last symbol gone
				end
				sym_cnt <= sym_cnt - 1'b1;
			end
		end
	end

	// byte and settings are sampled together
	always_ff @(posedge clk) begin
		if (byte_valid && byte_ready) begin
			shreg <= byte_data;
			mode_q <= mod_mode;
			inv_q <= freq_inv;
		end
		else if (sym_valid && sym_ready) begin
			shreg <= (mode_q == MOD_QPSK) ? {shreg[5:0], 2'b00} : {shreg[3:0], 4'b0000};
		end
	end

	always_comb begin
		if (mode_q == MOD_QPSK) begin
			re_pt = shreg[7] ? -QPSK_AMP : QPSK_AMP;
			im_pt = shreg[6] ? -QPSK_AMP : QPSK_AMP;
		end
		else begin
			re_pt = APSK16_RE[shreg[7:4]];
			im_pt = APSK16_IM[shreg[7:4]];
		end
		// spectrum inversion by I/Q swap
		sym_data.re = inv_q ? im_pt : re_pt;
		sym_data.im = inv_q ? re_pt : im_pt;
	end

endmodule

`default_nettype wire

/* design/symbol_interp2x.sv */
`timescale 1ns/100ps
`default_nettype none

module symbol_interp2x (
	input wire clk,
	input wire hard_rst_n,

	input dvb_mod_pkg::iq_t sym_data,
	input wire sym_valid,
	output logic sym_ready,

	output dvb_mod_pkg::iq_t smp_data,
	output logic smp_valid,
	input wire smp_ready
);

	import dvb_mod_pkg::*;

	logic cur_valid; // holding a symbol not fully emitted
	logic mid_phase; // next sample is the midpoint
	logic have_prev;
	iq_t cur_sym;
	iq_t prev_sym;
	iq_t mid_sym;

	// floor((a + b) / 2) without overflow
	function automatic sample_t midpoint(sample_t a, sample_t b);
		logic [16:0] sum;
		sum = {a[15], a} + {b[15], b};
		return sample_t'(sum[16:1]);
	endfunction

	assign sym_ready = !cur_valid;
	assign smp_valid = cur_valid;

	assign mid_sym.re = midpoint(prev_sym.re, cur_sym.re);
	assign mid_sym.im = midpoint(prev_sym.im, cur_sym.im);
	assign smp_data = mid_phase ? mid_sym : cur_sym;

	always_ff @(posedge clk) begin
		if (!hard_rst_n) begin
			cur_valid <= 1'b0;
			mid_phase <= 1'b0;
			have_prev <= 1'b0;
		end
		else begin
			if (sym_valid && sym_ready) begin
				cur_valid <= 1'b1;
				mid_phase <= have_prev; // very first symbol goes out alone
			end
			else if (smp_valid && smp_ready) begin
				if (mid_phase) begin
					mid_phase <= 1'b0;
				end
				else begin
					cur_valid <= 1'b0;
					have_prev <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (sym_valid && sym_ready) begin
			cur_sym <= sym_data;
		end
		if (smp_valid && smp_ready && !mid_phase) begin
			prev_sym <= cur_sym; // symbol itself delivered
		end
	end

endmodule

`default_nettype wire

/* design/dvb_mod_top.sv */
`timescale 1ns/100ps
`default_nettype none

module dvb_mod_top (
	input wire clk,
	input wire hard_rst_n,

	input wire wen,
	input dvb_mod_pkg::reg_addr_t waddr,
	input dvb_mod_pkg::reg_data_t wdata,
	input dvb_mod_pkg::reg_strb_t wstrb,
	input wire ren,
	input dvb_mod_pkg::reg_addr_t raddr,
	output dvb_mod_pkg::reg_data_t rdata,

	input dvb_mod_pkg::ts_byte_t ts_data,
	input wire ts_valid,
	output logic ts_ready,

	output dvb_mod_pkg::sample_t iq_re,
	output dvb_mod_pkg::sample_t iq_im,
	output logic iq_valid,
	input wire iq_ready
);

	import dvb_mod_pkg::*;

	mod_mode_t mod_mode;
	logic freq_inv;
	logic byte_fire;
	logic sample_fire;

	ts_byte_t byte_data;
	logic byte_valid;
	logic byte_ready;

	iq_t sym_data;
	logic sym_valid;
	logic sym_ready;

	iq_t smp_data;
	logic smp_valid;
	logic smp_ready;

	iq_t iq_out;

	assign byte_fire = ts_valid && ts_ready;
	assign sample_fire = iq_valid && iq_ready;
	assign iq_re = iq_out.re;
	assign iq_im = iq_out.im;

	dvb_cfg_regs u_regs (
		.clk(clk), .hard_rst_n(hard_rst_n),
		.wen(wen), .waddr(waddr), .wdata(wdata), .wstrb(wstrb),
		.ren(ren), .raddr(raddr), .rdata(rdata),
		.byte_fire(byte_fire), .sample_fire(sample_fire),
		.mod_mode(mod_mode), .freq_inv(freq_inv)
	);

	stream_stage #(.payload_t(ts_byte_t)) u_in_stage (
		.clk(clk), .hard_rst_n(hard_rst_n),
		.in_data(ts_data), .in_valid(ts_valid), .in_ready(ts_ready),
		.out_data(byte_data), .out_valid(byte_valid), .out_ready(byte_ready)
	);

	constellation_mapper u_mapper (
		.clk(clk), .hard_rst_n(hard_rst_n),
		.mod_mode(mod_mode), .freq_inv(freq_inv),
		.byte_data(byte_data), .byte_valid(byte_valid), .byte_ready(byte_ready),
		.sym_data(sym_data), .sym_valid(sym_valid), .sym_ready(sym_ready)
	);

	symbol_interp2x u_interp (
		.clk(clk), .hard_rst_n(hard_rst_n),
		.sym_data(sym_data), .sym_valid(sym_valid), .sym_ready(sym_ready),
		.smp_data(smp_data), .smp_valid(smp_valid), .smp_ready(smp_ready)
	);

	stream_stage #(.payload_t(iq_t)) u_out_stage (
		.clk(clk), .hard_rst_n(hard_rst_n),
		.in_data(smp_data), .in_valid(smp_valid), .in_ready(smp_ready),
		.out_data(iq_out), .out_valid(iq_valid), .out_ready(iq_ready)
	);

endmodule

`default_nettype wire

/* tests/dvb_mod_props.sv */
`timescale 1ns/100ps
`default_nettype none

module dvb_mod_props (
	input wire clk,
	input wire hard_rst_n,
	input dvb_mod_pkg::ts_byte_t ts_data,
	input wire ts_valid,
	input wire ts_ready,
	input dvb_mod_pkg::sample_t iq_re,
	input dvb_mod_pkg::sample_t iq_im,
	input wire iq_valid,
	input wire iq_ready
);

	// stalled input keeps its byte
	ts_hold: assert property (@(posedge clk) disable iff (!hard_rst_n)
		ts_valid && !ts_ready |=> ts_valid && $stable(ts_data))
		else $error("ts stream dropped valid or changed data while stalled");

	// stalled output keeps its sample
	iq_hold: assert property (@(posedge clk) disable iff (!hard_rst_n)
		iq_valid && !iq_ready |=> iq_valid && $stable(iq_re) && $stable(iq_im))
		else $error("iq stream dropped valid or changed data while stalled");

	iq_quiet_in_reset: assert property (@(posedge clk)
		!hard_rst_n |=> !iq_valid)
		else $error("iq_valid high during reset");

endmodule

bind dvb_mod_top dvb_mod_props u_props (
	.clk(clk),
	.hard_rst_n(hard_rst_n),
	.ts_data(ts_data),
	.ts_valid(ts_valid),
	.ts_ready(ts_ready),
	.iq_re(iq_re),
	.iq_im(iq_im),
	.iq_valid(iq_valid),
	.iq_ready(iq_ready)
);

`default_nettype wire

/* tests/dvb_mod_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module dvb_mod_tb;

	import dvb_mod_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int QPSK_BYTES = 60;
	localparam int APSK_BYTES = 60;
	localparam int WATCHDOG_CYCLES = (QPSK_BYTES + APSK_BYTES) * 40 + 2000;
	localparam reg_data_t CFG_MASK = 32'h1; // one used bit per config register

	logic clk = 1'b0;
	logic hard_rst_n;
	logic wen;
	reg_addr_t waddr;
	reg_data_t wdata;
	reg_strb_t wstrb;
	logic ren;
	reg_addr_t raddr;
	reg_data_t rdata;
	ts_byte_t ts_data;
	logic ts_valid;
	logic ts_ready;
	sample_t iq_re;
	sample_t iq_im;
	logic iq_valid;
	logic iq_ready;

	int seed = 54775;
	int bytes_in = 0;
	int samples_out = 0;
	bit ts_fire;
	iq_t exp_q[$]; // expected output samples in order
	iq_t prev_sym;
	bit have_prev = 1'b0;
	reg_data_t cfg_model[2] = '{32'h0, 32'h0};

	always #(CLK_PERIOD / 2) clk = ~clk;

	dvb_mod_top u_dut (
		.clk(clk), .hard_rst_n(hard_rst_n),
		.wen(wen), .waddr(waddr), .wdata(wdata), .wstrb(wstrb),
		.ren(ren), .raddr(raddr), .rdata(rdata),
		.ts_data(ts_data), .ts_valid(ts_valid), .ts_ready(ts_ready),
		.iq_re(iq_re), .iq_im(iq_im), .iq_valid(iq_valid), .iq_ready(iq_ready)
	);

	task automatic fail_stop();
		$display("=== FAIL ===");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_reg(reg_data_t got, reg_data_t want, string what);
		if (got !== want) begin
			$display("FAILED at %0t ns: %s got %h expected %h", $time, what, got, want);
			fail_stop();
		end
	endtask

	task automatic check_sample(iq_t got, iq_t want, int idx);
		if (got !== want) begin
			$display("FAILED at %0t ns: sample %0d got (%0d, %0d) expected (%0d, %0d)",
				$time, idx, got.re, got.im, want.re, want.im);
			fail_stop();
		end
	endtask

	function automatic bit chance(int pct);
		int r;
		r = $random(seed);
		return ((r & 32'h7fff_ffff) % 100) < pct;
	endfunction

	function automatic reg_data_t strobe_merge(reg_data_t old, reg_data_t upd, reg_strb_t s);
		reg_data_t r;
		r = old;
		for (int i = 0; i < REG_STRB_BITS; i++) begin
			if (s[i]) begin
				r[8*i +: 8] = upd[8*i +: 8];
			end
		end
		return r;
	endfunction

	// mean of two samples, rounded down
	function automatic sample_t floor_half_sum(sample_t a, sample_t b);
		int s;
		s = int'(a) + int'(b);
		return sample_t'(s >>> 1);
	endfunction

	task automatic push_symbol(sample_t re, sample_t im, bit inv);
		iq_t s;
		iq_t mid;
		s.re = inv ? im : re;
		s.im = inv ? re : im;
		if (have_prev) begin
			mid.re = floor_half_sum(prev_sym.re, s.re);
			mid.im = floor_half_sum(prev_sym.im, s.im);
			exp_q.push_back(mid);
		end
		exp_q.push_back(s);
		prev_sym = s;
		have_prev = 1'b1;
	endtask

	task automatic model_byte(ts_byte_t b, mod_mode_t mode, bit inv);
		sample_t re;
		sample_t im;
		if (mode == MOD_QPSK) begin
			for (int k = 0; k < 4; k++) begin
				re = b[7 - 2*k] ? -QPSK_AMP : QPSK_AMP; // bit pairs from the msb
				im = b[6 - 2*k] ? -QPSK_AMP : QPSK_AMP;
				push_symbol(re, im, inv);
			end
		end
		else begin
			push_symbol(APSK16_RE[b[7:4]], APSK16_IM[b[7:4]], inv); // high nibble first
			push_symbol(APSK16_RE[b[3:0]], APSK16_IM[b[3:0]], inv);
		end
	endtask

	task automatic write_reg(reg_addr_t a, reg_data_t d, reg_strb_t s);
		@(negedge clk);
		wen = 1'b1;
		waddr = a;
		wdata = d;
		wstrb = s;
		@(negedge clk);
		wen = 1'b0;
	endtask

	task automatic read_reg(reg_addr_t a, output reg_data_t d);
		@(negedge clk);
		ren = 1'b1;
		raddr = a;
		@(negedge clk);
		ren = 1'b0;
		d = rdata;
	endtask

	task automatic set_config(mod_mode_t mode, bit inv);
		reg_data_t rd;
		write_reg(ADDR_MOD_MODE, reg_data_t'(mode), 4'hf);
		write_reg(ADDR_FREQ_INV, reg_data_t'(inv), 4'hf);
		cfg_model[0] = reg_data_t'(mode);
		cfg_model[1] = reg_data_t'(inv);
		read_reg(ADDR_MOD_MODE, rd);
		check_reg(rd, cfg_model[0], "mod_mode readback");
		read_reg(ADDR_FREQ_INV, rd);
		check_reg(rd, cfg_model[1], "freq_inv readback");
	endtask

	task automatic take_sample();
		iq_t got;
		iq_t want;
		got.re = iq_re;
		got.im = iq_im;
		if (exp_q.size() == 0) begin
			$display("unexpected output sample at %0t ns, the model has none pending", $time);
			fail_stop();
		end
		else begin
			want = exp_q.pop_front();
			samples_out++;
			check_sample(got, want, samples_out);
		end
	endtask

	// transfers are decided at the falling edge and happen on the next rising edge
	task automatic run_stream(int n_bytes, mod_mode_t mode, bit inv);
		int bytes_left;
		bytes_left = n_bytes;
		ts_fire = 1'b0;
		while (bytes_left > 0 || exp_q.size() > 0) begin
			@(negedge clk);
			if (ts_fire) begin
				ts_valid = 1'b0; // byte taken
			end
			if (!ts_valid && bytes_left > 0 && chance(70)) begin
				ts_data = ts_byte_t'($random(seed));
				ts_valid = 1'b1;
			end
			ts_fire = ts_valid && ts_ready;
			if (ts_fire) begin
				bytes_left--;
				bytes_in++;
				model_byte(ts_data, mode, inv);
			end
			iq_ready = chance(70);
			if (iq_valid && iq_ready) begin
				take_sample();
			end
		end
		@(negedge clk);
		iq_ready = 1'b0;
	endtask

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("=== FAIL ===");
		$fatal(1, "watchdog expired");
	end

	initial begin
		reg_data_t rd;
		reg_addr_t a;
		reg_data_t d;
		reg_strb_t s;
		hard_rst_n = 1'b0;
		wen = 1'b0;
		waddr = '0;
		wdata = '0;
		wstrb = '0;
		ren = 1'b0;
		raddr = '0;
		ts_data = '0;
		ts_valid = 1'b0;
		iq_ready = 1'b0;
		repeat (4) @(negedge clk);
		hard_rst_n = 1'b1;
		@(negedge clk);
		if (!ts_ready) begin
			$display("ts_ready stayed low on the first cycle after reset");
			fail_stop();
		end
		check_reg(rdata, '0, "rdata after reset");

		for (int i = 0; i < 16; i++) begin
			read_reg(reg_addr_t'(i), rd);
			if (i < 4) begin
				check_reg(rd, '0, "reset value");
			end
			else begin
				check_reg(rd, {UNMAPPED_TAG, 16'(i)}, "unmapped read");
			end
		end

		// random strobed writes that the counters must ignore
		for (int i = 0; i < 24; i++) begin
			a = reg_addr_t'($random(seed) & 3);
			d = $random(seed);
			s = reg_strb_t'($random(seed));
			write_reg(a, d, s);
			if (a < 2) begin
				cfg_model[a[0]] = strobe_merge(cfg_model[a[0]], d, s) & CFG_MASK;
			end
			read_reg(a, rd);
			check_reg(rd, (a < 2) ? cfg_model[a[0]] : reg_data_t'(0), "register readback");
		end

		set_config(MOD_QPSK, 1'b0);
		run_stream(QPSK_BYTES, MOD_QPSK, 1'b0);
		set_config(MOD_APSK16, 1'b1); // stream is idle here
		run_stream(APSK_BYTES, MOD_APSK16, 1'b1);

		read_reg(ADDR_BYTE_COUNT, rd);
		check_reg(rd, reg_data_t'(bytes_in), "byte counter");
		read_reg(ADDR_SAMPLE_COUNT, rd);
		check_reg(rd, reg_data_t'(samples_out), "sample counter");

		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
design/dvb_mod_pkg.sv
design/stream_stage.sv
design/dvb_cfg_regs.sv
design/constellation_mapper.sv
design/symbol_interp2x.sv
design/dvb_mod_top.sv
tests/dvb_mod_props.sv
tests/dvb_mod_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it, judge from the log
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module dvb_mod_tb -f project.f -o sim_dvb_mod
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_dvb_mod > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx '=== PASS ===' "$log"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi
